// File: src/cond_pkg.sv
package cond_pkg;

  typedef struct packed {
    logic c;
    logic v;
    logic n;
    logic z;
  } flags_t;

  // even code and its negation side by side
  typedef enum logic [3:0] {
    eq,
    ne,
    cs,
    cc,
    mi,
    pl,
    vs,
    vc,
    hi,
    ls,
    ge,
    lt,
    gt,
    le,
    al,
    nv
  } cond_e;

endpackage

// File: src/exec_pkg.sv
package exec_pkg;

  localparam int data_w    = 64;
  localparam int half_w    = 32;
  localparam int reg_count = 16;
  localparam int reg_idx_w = $clog2(reg_count);
  localparam int shamt_w   = $clog2(data_w);

  typedef logic [reg_idx_w-1:0] reg_idx_t;
  typedef logic [data_w-1:0]    word_t;

  typedef enum logic [3:0] {
    op_add,
    op_sub,
    op_and,
    op_xor,
    op_or,
    op_shl,
    op_shr,
    op_sar,
    op_sxt,
    op_ldi
  } exec_op_e;

  // op_sxt selector, taken from b[1:0]
  typedef enum logic [1:0] {
    sxt_byte,
    sxt_half,
    sxt_word,
    sxt_bswap
  } sxt_sel_e;

  typedef struct packed {
    exec_op_e        op;
    cond_pkg::cond_e cond;
    reg_idx_t        rd;
    reg_idx_t        ra;
    reg_idx_t        rb;
    word_t           imm;
    logic            use_imm;
  } issue_t;

  typedef struct packed {
    reg_idx_t         rd;
    word_t            value;
    cond_pkg::flags_t flags;
    logic             executed;
  } result_t;

endpackage

// File: src/cond_eval.sv
`timescale 1ns/1ps

module cond_eval (
  input  cond_pkg::cond_e  cond,
  input  cond_pkg::flags_t flags,
  output logic             pass
);
  import cond_pkg::*;

  logic base;
  logic sign_ok;

  assign sign_ok = flags.n == flags.v;

  // only the even code is decoded, bit 0 inverts it
  always_comb begin
    case (cond)
      eq, ne: begin
        base = flags.z;
      end
      cs, cc: begin
        base = flags.c;
      end
      mi, pl: begin
        base = flags.n;
      end
      vs, vc: begin
        base = flags.v;
      end
      hi, ls: begin
        base = flags.c & ~flags.z; // unsigned higher
      end
      ge, lt: begin
        base = sign_ok;
      end
      gt, le: begin
        base = sign_ok & ~flags.z;
      end
      default: begin
        base = 1'b1; // al, nv
      end
    endcase
  end

  assign pass = base ^ cond[0];

endmodule

// File: src/reg_file.sv
`timescale 1ns/1ps

module reg_file (
  input  logic               clk,
  input  logic               rst,
  input  exec_pkg::reg_idx_t ra,
  input  exec_pkg::reg_idx_t rb,
  output exec_pkg::word_t    ra_data,
  output exec_pkg::word_t    rb_data,
  output cond_pkg::flags_t   flags,
  input  logic               wr_en,
  input  exec_pkg::reg_idx_t wr_rd,
  input  exec_pkg::word_t    wr_data,
  input  logic               flag_en,
  input  cond_pkg::flags_t   flag_data
);
  import exec_pkg::*;

  word_t regs [reg_count];

  // asynchronous read ports
  assign ra_data = regs[ra];
  assign rb_data = regs[rb];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < reg_count; i++) begin
        regs[i] <= '0;
      end
      flags <= '0;
    end else begin
      if (wr_en) begin
        regs[wr_rd] <= wr_data;
      end
      if (flag_en) begin
        flags <= flag_data; // whole nzcv set at once
      end
    end
  end

endmodule

// File: src/exec_lo_stage.sv
`timescale 1ns/1ps

module exec_lo_stage (
  input  exec_pkg::issue_t            op,
  input  exec_pkg::word_t             ra_data,
  input  exec_pkg::word_t             rb_data,
  input  cond_pkg::flags_t            flags,
  output logic [exec_pkg::half_w-1:0] lo_word,
  output logic                        carry32,
  output logic                        cond_pass
);
  import exec_pkg::*;

  word_t              b;
  logic               is_sub;
  logic [half_w-1:0]  a_lo;
  logic [half_w-1:0]  b_lo;
  logic [half_w-1:0]  b_add;
  logic [half_w:0]    sum;
  logic [shamt_w-1:0] shamt;
  word_t              shl_full;
  word_t              shr_full;
  word_t              sar_full;

  assign b      = op.use_imm ? op.imm : rb_data;
  assign is_sub = op.op == op_sub;
  assign a_lo   = ra_data[half_w-1:0];
  assign b_lo   = b[half_w-1:0];

  // sub is a + ~b + 1
  assign b_add = is_sub ? ~b_lo : b_lo;
  assign sum   = {1'b0, a_lo} + {1'b0, b_add} + {{half_w{1'b0}}, is_sub};

  assign shamt    = b[shamt_w-1:0];
  assign shl_full = ra_data << shamt;
  assign shr_full = ra_data >> shamt;
  assign sar_full = $signed(ra_data) >>> shamt;

  always_comb begin
    carry32 = 1'b0;
    case (op.op)
      op_add, op_sub: begin
        lo_word = sum[half_w-1:0];
        carry32 = sum[half_w]; // handed to stage two
      end
      op_and: lo_word = a_lo & b_lo;
      op_xor: lo_word = a_lo ^ b_lo;
      op_or:  lo_word = a_lo | b_lo;
      op_shl: lo_word = shl_full[half_w-1:0];
      op_shr: lo_word = shr_full[half_w-1:0];
      op_sar: lo_word = sar_full[half_w-1:0];
      op_sxt: begin
        case (sxt_sel_e'(b[1:0]))
          sxt_byte:  lo_word = {{24{a_lo[7]}}, a_lo[7:0]};
          sxt_half:  lo_word = {{16{a_lo[15]}}, a_lo[15:0]};
          sxt_word:  lo_word = a_lo;
          default:   lo_word = {a_lo[7:0], a_lo[15:8], a_lo[23:16], a_lo[31:24]};
        endcase
      end
      op_ldi: lo_word = b_lo;
      default: lo_word = '0;
    endcase
  end

  // condition checked against flags as they stand now
  cond_eval i_cond (
    .cond  (op.cond),
    .flags (flags),
    .pass  (cond_pass)
  );

endmodule

// File: src/exec_hi_stage.sv
`timescale 1ns/1ps

module exec_hi_stage (
  input  exec_pkg::issue_t            op,
  input  exec_pkg::word_t             a,
  input  exec_pkg::word_t             b,
  input  logic [exec_pkg::half_w-1:0] lo_word,
  input  logic                        carry32,
  input  logic                        cond_pass,
  output exec_pkg::result_t           res,
  output logic                        wr_en,
  output logic                        flag_en,
  output cond_pkg::flags_t            flag_data
);
  import exec_pkg::*;
  import cond_pkg::*;

  logic               is_arith;
  logic [half_w-1:0]  a_hi;
  logic [half_w-1:0]  b_hi;
  logic [half_w-1:0]  b_add;
  logic [half_w:0]    sum;
  logic [half_w-1:0]  hi_word;
  logic [shamt_w-1:0] shamt;
  word_t              shl_full;
  word_t              shr_full;
  word_t              sar_full;
  word_t              value;
  flags_t             res_flags;

  assign is_arith = op.op inside {op_add, op_sub};
  assign a_hi     = a[data_w-1:half_w];
  assign b_hi     = b[data_w-1:half_w];

  // carry from the low word replaces the +1 of sub
  assign b_add = (op.op == op_sub) ? ~b_hi : b_hi;
  assign sum   = {1'b0, a_hi} + {1'b0, b_add} + {{half_w{1'b0}}, carry32};

  assign shamt    = b[shamt_w-1:0];
  assign shl_full = a << shamt;
  assign shr_full = a >> shamt;
  assign sar_full = $signed(a) >>> shamt;

  always_comb begin
    case (op.op)
      op_add, op_sub: hi_word = sum[half_w-1:0];
      op_and: hi_word = a_hi & b_hi;
      op_xor: hi_word = a_hi ^ b_hi;
      op_or:  hi_word = a_hi | b_hi;
      op_shl: hi_word = shl_full[data_w-1:half_w];
      op_shr: hi_word = shr_full[data_w-1:half_w];
      op_sar: hi_word = sar_full[data_w-1:half_w];
      op_sxt: begin
        case (sxt_sel_e'(b[1:0]))
          sxt_byte:  hi_word = {half_w{a[7]}};
          sxt_half:  hi_word = {half_w{a[15]}};
          sxt_word:  hi_word = {half_w{a[31]}};
          default:   hi_word = '0; // swapped word is zero-extended
        endcase
      end
      op_ldi: hi_word = b_hi;
      default: hi_word = '0;
    endcase
  end

  assign value = {hi_word, lo_word};

  always_comb begin
    flag_data.n = value[data_w-1];
    flag_data.z = value == '0;
    flag_data.c = is_arith & sum[half_w];
    // overflow when both inputs agree in sign and the result does not
    flag_data.v = is_arith & (a[data_w-1] == b_add[half_w-1])
                & (hi_word[half_w-1] != a[data_w-1]);
  end

  assign wr_en     = cond_pass;
  assign flag_en   = cond_pass && op.op != op_ldi;
  assign res_flags = cond_pass ? flag_data : '0;

  assign res = '{
    rd:       op.rd,
    value:    cond_pass ? value : '0,
    flags:    res_flags,
    executed: cond_pass
  };

endmodule

// File: src/exec_unit.sv
`timescale 1ns/1ps

module exec_unit (
  input  logic              clk,
  input  logic              rst,
  input  logic              in_valid,
  output logic              in_ready,
  input  exec_pkg::issue_t  in_op,
  output logic              out_valid,
  input  logic              out_ready,
  output exec_pkg::result_t out_res
);
  import exec_pkg::*;
  import cond_pkg::*;

  typedef struct packed {
    issue_t            op;
    word_t             a;
    word_t             b;
    logic [half_w-1:0] lo;
    logic              carry32;
    logic              cond_pass;
  } lo_word_t;

  issue_t            s1_op;
  logic              s1_valid;
  lo_word_t          s2;
  logic              s2_valid;
  lo_word_t          s2_next;
  word_t             ra_data;
  word_t             rb_data;
  flags_t            flags;
  logic [half_w-1:0] lo_word;
  logic              carry32;
  logic              cond_pass;
  logic              hi_wr_en;
  logic              hi_flag_en;
  flags_t            hi_flag_data;
  logic              out_fire;
  logic              s2_free;
  logic              s1_free;
  logic              hazard;

  // older op blocks a new one on a register or a flag dependency
  function automatic logic depends_on(issue_t held, issue_t nxt);
    logic raw;
    logic flag_dep;
    raw      = held.rd == nxt.ra || held.rd == nxt.rb;
    flag_dep = !(nxt.cond inside {al, nv}) && held.op != op_ldi;
    return raw || flag_dep;
  endfunction

  assign hazard = (s1_valid && depends_on(s1_op, in_op))
               || (s2_valid && depends_on(s2.op, in_op));

  assign out_fire = s2_valid && out_ready;
  assign s2_free  = !s2_valid || out_ready;
  assign s1_free  = !s1_valid || s2_free;
  assign in_ready = s1_free && !hazard;

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
    end else begin
      if (s1_free) s1_valid <= in_valid && in_ready;
      if (s2_free) s2_valid <= s1_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && in_ready) s1_op <= in_op;
    if (s2_free && s1_valid) s2 <= s2_next;
  end

  reg_file i_regs (
    .clk       (clk),
    .rst       (rst),
    .ra        (s1_op.ra),
    .rb        (s1_op.rb),
    .ra_data   (ra_data),
    .rb_data   (rb_data),
    .flags     (flags),
    .wr_en     (out_fire && hi_wr_en), // retire on transfer out
    .wr_rd     (s2.op.rd),
    .wr_data   (out_res.value),
    .flag_en   (out_fire && hi_flag_en),
    .flag_data (hi_flag_data)
  );

  exec_lo_stage i_lo (
    .op        (s1_op),
    .ra_data   (ra_data),
    .rb_data   (rb_data),
    .flags     (flags),
    .lo_word   (lo_word),
    .carry32   (carry32),
    .cond_pass (cond_pass)
  );

  assign s2_next = '{
    op:        s1_op,
    a:         ra_data,
    b:         s1_op.use_imm ? s1_op.imm : rb_data,
    lo:        lo_word,
    carry32:   carry32,
    cond_pass: cond_pass
  };

  exec_hi_stage i_hi (
    .op        (s2.op),
    .a         (s2.a),
    .b         (s2.b),
    .lo_word   (s2.lo),
    .carry32   (s2.carry32),
    .cond_pass (s2.cond_pass),
    .res       (out_res),
    .wr_en     (hi_wr_en),
    .flag_en   (hi_flag_en),
    .flag_data (hi_flag_data)
  );

  assign out_valid = s2_valid;

endmodule

// File: tb/exec_checker.sv
`timescale 1ns/1ps

module exec_checker (
  input logic              clk,
  input logic              rst,
  input logic              out_valid,
  input logic              out_ready,
  input exec_pkg::result_t out_res
);
  import exec_pkg::*;

  result_t expected_q[$];
  int      test_num;
  int      pass_count;
  int      fail_count;

  task automatic expect_result(input result_t exp);
    expected_q.push_back(exp);
  endtask

  function automatic int pending();
    return expected_q.size();
  endfunction

  function automatic int field_differs(input string name, input logic [63:0] exp_v,
                                       input logic [63:0] act_v);
    if (exp_v !== act_v) begin
      $display("FAIL %0t ns: out_res.%s expected %h, got %h", $time, name, exp_v, act_v);
      return 1;
    end
    return 0;
  endfunction

  task automatic check_result(input result_t act);
    result_t exp;
    int      errs;
    test_num++;
    if (expected_q.size() == 0) begin
      $display("test %0d: result for r%0d arrived with no expected entry left",
               test_num, act.rd);
      fail_count++;
    end else begin
      exp  = expected_q.pop_front();
      errs = field_differs("executed", exp.executed, act.executed);
      if (exp.executed) errs += field_differs("value", exp.value, act.value);
      errs += field_differs("flags", exp.flags, act.flags);
      errs += field_differs("rd", exp.rd, act.rd);
      if (errs == 0) begin
        pass_count++;
        $display("test %0d: ok, r%0d = %h flags %b", test_num, act.rd, act.value, act.flags);
      end else begin
        fail_count++;
        $display("test %0d: %0d field(s) wrong", test_num, errs);
      end
    end
  endtask

  // sampled like a flop, before the DUT updates
  always @(posedge clk) begin
    if (!rst && out_valid && out_ready) check_result(out_res);
  end

endmodule

// File: tb/tb_exec_unit.sv
`timescale 1ns/1ps

module tb_exec_unit;
  import exec_pkg::*;
  import cond_pkg::*;

  localparam string golden_path = "tb/golden_ops.txt";

  logic    clk;
  logic    rst;
  logic    in_valid;
  logic    in_ready;
  issue_t  in_op;
  logic    out_valid;
  logic    out_ready;
  result_t out_res;

  issue_t  stim_q[$];
  integer  seed;
  int      cycles;
  int      cycle_limit;
  int      load_errors;
  int      leftover;

  exec_unit i_dut (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_ready  (in_ready),
    .in_op     (in_op),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_res   (out_res)
  );

  exec_checker i_checker (
    .clk       (clk),
    .rst       (rst),
    .out_valid (out_valid),
    .out_ready (out_ready),
    .out_res   (out_res)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // '#' lines are comments, fields are hex
  task automatic load_vectors();
    int          fd;
    int          n;
    string       line;
    issue_t      stim;
    result_t     exp;
    logic [3:0]  op_code;
    logic [3:0]  cond_code;
    logic [3:0]  rd;
    logic [3:0]  ra;
    logic [3:0]  rb;
    logic [3:0]  flg;
    logic [63:0] imm;
    logic [63:0] val;
    logic        use_imm;
    logic        executed;
    fd = $fopen(golden_path, "r");
    if (fd == 0) begin
      $display("cannot open golden file %s", golden_path);
      load_errors++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        if (line.len() > 0 && line[0] != "#") begin
          n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h", op_code, cond_code,
                      rd, ra, rb, imm, use_imm, executed, val, flg);
          if (n == 10) begin
            stim.op       = exec_op_e'(op_code);
            stim.cond     = cond_e'(cond_code);
            stim.rd       = rd;
            stim.ra       = ra;
            stim.rb       = rb;
            stim.imm      = imm;
            stim.use_imm  = use_imm;
            exp.rd        = rd;
            exp.value     = val;
            exp.flags     = flg;
            exp.executed  = executed;
            stim_q.push_back(stim);
            i_checker.expect_result(exp);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic issue_one(input issue_t stim);
    logic taken;
    taken = 1'b0;
    @(negedge clk);
    in_valid = 1'b1;
    in_op    = stim;
    while (!taken) begin
      @(posedge clk);
      taken = in_ready; // still the value from before the edge
    end
  endtask

  // ready three cycles in four once reset is released
  initial begin : ready_gen
    wait (rst === 1'b0);
    forever begin
      @(negedge clk);
      out_ready = ($random(seed) & 3) != 0;
    end
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
  end

  initial begin : watchdog
    wait (cycle_limit > 0 && cycles >= cycle_limit);
    $display("timeout after %0d cycles, %0d of %0d results checked", cycles,
             i_checker.test_num, stim_q.size());
    $display("TEST FAILED");
    $finish;
  end

  initial begin : main
    rst         = 1'b1;
    in_valid    = 1'b0;
    in_op       = '0;
    out_ready   = 1'b0;
    seed        = 32'h8043_2f83;
    cycles      = 0;
    cycle_limit = 0;
    load_errors = 0;
    load_vectors();
    cycle_limit = 30 * stim_q.size() + 50;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    foreach (stim_q[i]) begin
      issue_one(stim_q[i]);
    end
    @(negedge clk);
    in_valid = 1'b0;
    while (i_checker.test_num < stim_q.size()) begin
      @(posedge clk);
    end
    repeat (5) @(posedge clk); // catch stray results
    leftover = i_checker.pending();
    if (leftover > 0) $display("%0d expected results never arrived", leftover);
    if (stim_q.size() == 0) $display("golden file held no instructions");
    $display("results checked %0d, passed %0d, failed %0d", i_checker.test_num,
             i_checker.pass_count, i_checker.fail_count);
    if (i_checker.fail_count == 0 && leftover == 0 && load_errors == 0
        && stim_q.size() > 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

// File: tb/golden_ops.txt
# op cond rd ra rb imm use_imm | expected: executed value flags, all hex
# flags are {c,v,n,z}; op and cond are the enum codes
9 e 1 0 0 00000000ffffffff 1 1 00000000ffffffff 0
9 e 2 0 0 7fffffffffffffff 1 1 7fffffffffffffff 0
0 e 3 1 0 0000000000000001 1 1 0000000100000000 0
0 e 4 2 1 0000000000000000 0 1 80000000fffffffe 6
1 6 5 1 1 0000000000000000 0 1 0000000000000000 9
1 0 6 5 0 0000000000000001 1 1 ffffffffffffffff 2
0 b 7 6 0 0000000000000002 1 1 0000000000000001 8
2 8 8 6 0 f0f0f0f00f0f0f0f 1 1 f0f0f0f00f0f0f0f 2
3 4 9 8 6 0000000000000000 0 1 0f0f0f0ff0f0f0f0 0
4 5 a 9 8 0000000000000000 0 1 ffffffffffffffff 2
2 1 b 9 0 f0f0f0f00f0f0f0f 1 1 0000000000000000 1
5 d c 4 0 000000000000001f 1 1 7fffffff00000000 0
6 c d 4 0 0000000000000020 1 1 0000000080000000 0
7 3 e 4 0 000000000000003f 1 1 ffffffffffffffff 2
5 9 f 4 5 0000000000000000 0 1 80000000fffffffe 2
9 e 1 0 0 deadbeef12348680 1 1 deadbeef12348680 2
8 e 3 1 0 0000000000000000 1 1 ffffffffffffff80 2
8 7 5 1 0 0000000000000001 1 1 ffffffffffff8680 2
8 e 7 1 0 0000000000000002 1 1 0000000012348680 0
8 e 8 1 0 0000000000000003 1 1 0000000080863412 0
9 e 9 0 0 8000000000000000 1 1 8000000000000000 2
0 4 9 9 0 0000000000000001 1 0 0000000000000000 0
0 2 a a 0 0000000000000001 1 0 0000000000000000 0
1 f 9 9 2 0000000000000000 0 0 0000000000000000 0
4 a b 9 0 0000000000000000 1 1 8000000000000000 2
0 e c a b 0000000000000000 0 1 7fffffffffffffff c
1 6 d c 2 0000000000000000 0 1 0000000000000000 9
0 9 e d 0 0000000000000005 1 1 0000000000000005 0

// File: sim.f
src/cond_pkg.sv
src/exec_pkg.sv
src/cond_eval.sv
src/reg_file.sv
src/exec_lo_stage.sv
src/exec_hi_stage.sv
src/exec_unit.sv
tb/exec_checker.sv
tb/tb_exec_unit.sv

// File: Bender.yml
package:
  name: exec_slice

sources:
  - src/cond_pkg.sv
  - src/exec_pkg.sv
  - src/cond_eval.sv
  - src/reg_file.sv
  - src/exec_lo_stage.sv
  - src/exec_hi_stage.sv
  - src/exec_unit.sv
  - target: test
    files:
      - tb/exec_checker.sv
      - tb/tb_exec_unit.sv
